// File: flist.f
+incdir+hdl
hdl/ahb_pkg.sv
hdl/mtx_pkg.sv
hdl/out_stage_arb.sv
hdl/port_mux.sv
hdl/data_phase_ctrl.sv
hdl/ahb_out_stage.sv
tests/tb_ahb_out_stage.sv

// File: tests/tb_ahb_out_stage.sv
// AHB output stage testbench

`include "ahb_mtx_macros.svh"

module tb_ahb_out_stage;

  timeunit 1ns;
  timeprecision 1ps;

  import ahb_pkg::*;
  import mtx_pkg::*;

  localparam int MAX_CYCLES = 1500;  // Reset, directed rounds and random run

  logic                      HCLK = 1'b0;
  logic                      HRESETn;
  ahb_addr_t                 i_addr      [`MTX_NUM_PORTS];
  logic [`MTX_NUM_PORTS-1:0] i_held_tran;
  ahb_wdata_t                i_wdata     [`MTX_NUM_PORTS];
  logic                      i_hreadyout;
  ahb_addr_t                 o_addr;
  ahb_wdata_t                o_wdata;
  logic                      o_hreadymux;
  logic [`MTX_NUM_PORTS-1:0] o_active;

  // Reference model state
  port_idx_t                 m_port;      // Expected grant port
  logic                      m_none;      // Expected no-grant flag
  logic                      m_lock;      // Expected lock-held flag
  port_idx_t                 m_dport;     // Expected data phase port
  logic                      m_ssel;      // Expected slave-select
  ahb_addr_t                 exp_addr;
  ahb_wdata_t                exp_wdata;
  logic [`MTX_NUM_PORTS-1:0] exp_active;
  logic                      exp_ready;
  logic [`MTX_NUM_PORTS-1:0] m_req;
  logic                      m_hold;
  logic [`MTX_NUM_PORTS-1:0] prev_active; // Values one edge back
  ahb_wdata_t                prev_wdata;
  int                        cycle_count;
  int unsigned               seed_val;

  ahb_out_stage ahb_out_stage_i
  (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_addr      (i_addr),
    .i_held_tran (i_held_tran),
    .i_wdata     (i_wdata),
    .i_hreadyout (i_hreadyout),
    .o_addr      (o_addr),
    .o_wdata     (o_wdata),
    .o_hreadymux (o_hreadymux),
    .o_active    (o_active)
  );

  always #10 HCLK = ~HCLK;  // 20 ns period

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  always_comb
  begin
    exp_addr   = '0;
    exp_active = '0;
    if (!m_none)
    begin
      exp_addr             = i_addr[m_port];
      exp_active[m_port]   = 1'b1;
    end
    exp_ready = m_ssel ? i_hreadyout : 1'b1;  // Unselected phase never stalls
    exp_wdata = i_wdata[m_dport];
    for (int i = 0; i < `MTX_NUM_PORTS; i++)
      m_req[i] = i_held_tran[i] & i_addr[i].sel;
    // Lock hold or burst hold
    m_hold = (exp_addr.mastlock & (exp_addr.sel | m_lock)) |
             (exp_addr.sel & ((exp_addr.trans == SEQ) | (exp_addr.trans == BUSY)));
  end

  always @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      m_port  <= '0;
      m_none  <= 1'b1;
      m_lock  <= 1'b0;
      m_dport <= '0;
      m_ssel  <= 1'b0;
    end
    else if (exp_ready)
    begin
      m_dport <= m_port;        // Accepted phase enters data phase
      m_ssel  <= exp_addr.sel;
      if (!m_hold)
      begin
        // Lowest requester wins
        if (m_req[0])
          {m_none, m_port} <= {1'b0, 2'd0};
        else if (m_req[1])
          {m_none, m_port} <= {1'b0, 2'd1};
        else if (m_req[2])
          {m_none, m_port} <= {1'b0, 2'd2};
        else
          {m_none, m_port} <= {1'b1, 2'd0};
      end
      if (exp_addr.sel && exp_addr.mastlock &&
          (exp_addr.trans == NONSEQ || exp_addr.trans == SEQ))
        m_lock <= 1'b1;
      else if (!exp_addr.mastlock)
        m_lock <= 1'b0;
    end
  end

  always @(posedge HCLK)
  begin
    prev_active <= o_active;
    prev_wdata  <= o_wdata;
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
    $display("test failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  a_active: assert property (@(posedge HCLK) disable iff (!HRESETn)
    o_active == exp_active)
    else report_mismatch("o_active", $sampled(exp_active), $sampled(o_active));

  a_addr: assert property (@(posedge HCLK) disable iff (!HRESETn)
    o_addr == exp_addr)
    else report_mismatch("o_addr", $sampled(exp_addr), $sampled(o_addr));

  a_wdata: assert property (@(posedge HCLK) disable iff (!HRESETn)
    o_wdata == exp_wdata)
    else report_mismatch("o_wdata", $sampled(exp_wdata), $sampled(o_wdata));

  a_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
    o_hreadymux == exp_ready)
    else report_mismatch("o_hreadymux", $sampled(exp_ready), $sampled(o_hreadymux));

  // Nothing moves during a stall
  a_stall_active: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !o_hreadymux |=> (o_active == prev_active))
    else report_mismatch("o_active", $sampled(prev_active), $sampled(o_active));

  a_stall_wdata: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !o_hreadymux |=> (o_wdata == prev_wdata))
    else report_mismatch("o_wdata", $sampled(prev_wdata), $sampled(o_wdata));

  // Owner kept through SEQ/BUSY beats and locked sequences
  a_burst_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (exp_ready && exp_addr.sel && (exp_addr.trans inside {SEQ, BUSY}))
      |=> (o_active == prev_active))
    else report_mismatch("o_active", $sampled(prev_active), $sampled(o_active));

  a_lock_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (exp_ready && exp_addr.mastlock && (exp_addr.sel || m_lock))
      |=> (o_active == prev_active))
    else report_mismatch("o_active", $sampled(prev_active), $sampled(o_active));

  // Run limit
  always @(posedge HCLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("timeout, run went past %0d cycles without finishing", MAX_CYCLES);
      $display("test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  function automatic ahb_addr_t make_addr(input logic sel, input htrans_e trans,
                                          input logic lock);
    ahb_addr_t a;
    a          = '0;
    a.sel      = sel;
    a.addr     = $urandom;
    a.trans    = trans;
    a.write    = $urandom_range(1, 0);
    a.size     = 3'b010;                  // Word
    a.burst    = $urandom_range(7, 0);
    a.prot     = $urandom_range(15, 0);
    a.master   = $urandom_range(7, 0);
    a.mastlock = lock;
    return a;
  endfunction

  task automatic drive_port(input int p, input logic held, input logic sel,
                            input htrans_e trans, input logic lock);
    i_held_tran[p] <= held;
    i_addr[p]      <= make_addr(sel, trans, lock);
    i_wdata[p]     <= $urandom;
  endtask

  task automatic idle_ports();
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
    begin
      i_held_tran[p] <= 1'b0;
      i_addr[p]      <= make_addr(1'b0, IDLE, 1'b0);
    end
  endtask

  // Advance to the next edge that accepts an address phase
  task automatic next_accept();
    do
      @(posedge HCLK);
    while (!o_hreadymux);
  endtask

  task automatic stall_slave(input int n);
    i_hreadyout <= 1'b0;
    repeat (n) @(posedge HCLK);
    i_hreadyout <= 1'b1;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    HRESETn     = 1'b0;
    i_hreadyout = 1'b1;
    i_held_tran = '0;
    cycle_count = 0;
    seed_val    = $urandom(86400);  // Single seed for the run
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
    begin
      i_addr[p]  = '0;
      i_wdata[p] = 32'h1000_0000 + p;
    end
    repeat (3) @(posedge HCLK);
    HRESETn <= 1'b1;
    next_accept();

    repeat (3)
    begin
      // Priority over every request mask with port 1 selected but not held
      for (int m = 0; m < 8; m++)
      begin
        next_accept();
        for (int p = 0; p < `MTX_NUM_PORTS; p++)
          drive_port(p, m[p], m[p] | (p == 1), NONSEQ, 1'b0);
        next_accept();
        idle_ports();
      end

      // Burst hold against port 0
      for (int hp = 1; hp < `MTX_NUM_PORTS; hp++)
      begin
        next_accept();
        drive_port(hp, 1'b1, 1'b1, NONSEQ, 1'b0);
        for (int beat = 0; beat < 4; beat++)
        begin
          next_accept();
          drive_port(hp, 1'b1, 1'b1, (beat == 2) ? BUSY : SEQ, 1'b0);
          if (beat == 0)
            drive_port(0, 1'b1, 1'b1, NONSEQ, 1'b0);
          if (beat == 1)
            stall_slave(2);
        end
        next_accept();
        drive_port(hp, 1'b0, 1'b0, IDLE, 1'b0);  // Burst ends and port 0 takes over
        next_accept();
        idle_ports();
      end

      // Locked sequence with sel dropped partway
      next_accept();
      drive_port(1, 1'b1, 1'b1, NONSEQ, 1'b1);
      next_accept();
      drive_port(1, 1'b1, 1'b1, SEQ, 1'b1);
      drive_port(0, 1'b1, 1'b1, NONSEQ, 1'b0);
      next_accept();
      drive_port(1, 1'b0, 1'b0, IDLE, 1'b1);
      repeat (3) next_accept();
      drive_port(1, 1'b0, 1'b0, IDLE, 1'b0);     // Lock released
      next_accept();
      next_accept();
      idle_ports();
    end

    // Random traffic with inputs held while stalled
    for (int n = 0; n < 1000; n++)
    begin
      @(posedge HCLK);
      i_hreadyout <= ($urandom_range(3, 0) != 0);
      if (o_hreadymux)
      begin
        for (int p = 0; p < `MTX_NUM_PORTS; p++)
          drive_port(p, $urandom_range(1, 0), $urandom_range(1, 0),
                     htrans_e'($urandom_range(3, 0)), $urandom_range(4, 0) == 0);
      end
    end

    i_hreadyout <= 1'b1;
    next_accept();
    idle_ports();
    repeat (3) @(posedge HCLK);
    $display("test passed");
    $finish;
  end

endmodule

// File: hdl/ahb_out_stage.sv
// AHB matrix output stage for one slave port

`include "ahb_mtx_macros.svh"

module ahb_out_stage
(
  input  logic                      HCLK,
  input  logic                      HRESETn,

  // Input stages
  input  ahb_pkg::ahb_addr_t        i_addr      [`MTX_NUM_PORTS],  // Address/control
  input  logic [`MTX_NUM_PORTS-1:0] i_held_tran,                   // Held transfer flags
  input  ahb_pkg::ahb_wdata_t       i_wdata     [`MTX_NUM_PORTS],  // Write data

  // Shared slave
  input  logic                      i_hreadyout,  // Slave ready feedback
  output ahb_pkg::ahb_addr_t        o_addr,       // Address/control to slave
  output ahb_pkg::ahb_wdata_t       o_wdata,      // Write data to slave
  output logic                      o_hreadymux,  // Multiplexed ready
  output logic [`MTX_NUM_PORTS-1:0] o_active      // Port owns address phase
);

  import ahb_pkg::*;
  import mtx_pkg::*;

  logic [`MTX_NUM_PORTS-1:0] req;        // Qualified requests
  grant_t                    grant;      // Address phase owner
  grant_t                    data_grant; // Data phase owner
  ahb_addr_t                 addr_sel;   // Granted address phase
  logic                      hreadymux;

  // ----------------------------------------------------------------------
  // Request qualification
  // ----------------------------------------------------------------------
  // Port asks only with a pending transfer aimed at this slave
  always_comb
  begin
    for (int i = 0; i < `MTX_NUM_PORTS; i++)
      req[i] = i_held_tran[i] & i_addr[i].sel;
  end

  // ----------------------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------------------
  out_stage_arb u_arb
  (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_req       (req),
    .i_hreadymux (hreadymux),
    .i_addr_sel  (addr_sel),
    .o_grant     (grant)
  );

  // One-hot owner decode
  always_comb
  begin
    o_active = '0;
    if (!grant.none)
      o_active[grant.port] = 1'b1;
  end

  // ----------------------------------------------------------------------
  // Address and write data paths
  // ----------------------------------------------------------------------
  port_mux #(.payload_t(ahb_addr_t)) u_addr_mux
  (
    .i_payload (i_addr),
    .i_grant   (grant),
    .o_payload (addr_sel)
  );

  port_mux #(.payload_t(ahb_wdata_t)) u_data_mux
  (
    .i_payload (i_wdata),
    .i_grant   (data_grant),   // none never set here
    .o_payload (o_wdata)
  );

  // ----------------------------------------------------------------------
  // Data phase control
  // ----------------------------------------------------------------------
  data_phase_ctrl u_data_ctrl
  (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_grant      (grant),
    .i_sel        (addr_sel.sel),
    .i_hreadyout  (i_hreadyout),
    .o_data_grant (data_grant),
    .o_hreadymux  (hreadymux)
  );

  assign o_addr      = addr_sel;
  assign o_hreadymux = hreadymux;  // Also back to the input stages

endmodule

// File: hdl/data_phase_ctrl.sv
// Data phase tracking and ready multiplexer

`include "ahb_mtx_macros.svh"

module data_phase_ctrl
(
  input  logic            HCLK,
  input  logic            HRESETn,
  input  mtx_pkg::grant_t i_grant,       // Address phase owner
  input  logic            i_sel,         // Selected port HSEL
  input  logic            i_hreadyout,   // Slave ready feedback
  output mtx_pkg::grant_t o_data_grant,  // Data phase owner
  output logic            o_hreadymux    // Multiplexed ready
);

  import mtx_pkg::*;

  port_idx_t data_port_q;  // Port in data phase
  logic      slave_sel_q;  // Data phase addressed this slave

  // ----------------------------------------------------------------------
  // Data phase registers
  // ----------------------------------------------------------------------
  // Address phase moves into data phase on ready high
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port_q <= '0;
      slave_sel_q <= 1'b0;
    end
    else if (o_hreadymux)
    begin
      data_port_q <= i_grant.port;
      slave_sel_q <= i_sel;
    end
  end

  // Write data always follows some port
  assign o_data_grant.port = data_port_q;
  assign o_data_grant.none = 1'b0;

  // ----------------------------------------------------------------------
  // Ready generation
  // ----------------------------------------------------------------------
  // Slave only stalls a data phase it was selected for
  assign o_hreadymux = slave_sel_q ? i_hreadyout : 1'b1;

  // Unselected phase finishes at once
  a_unsel_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (o_hreadymux && !i_sel) |=> o_hreadymux);

endmodule

// File: hdl/port_mux.sv
// Per-port payload selector

`include "ahb_mtx_macros.svh"

module port_mux
#(
  parameter type payload_t = logic [`AHB_DATA_W-1:0]  // Payload carried per port
)
(
  input  payload_t        i_payload [`MTX_NUM_PORTS],  // One payload per port
  input  mtx_pkg::grant_t i_grant,                     // Port to pass through
  output payload_t        o_payload
);

  import mtx_pkg::*;

  port_idx_t sel_idx;  // Chosen port

  assign sel_idx = i_grant.port;

  // Zero when nobody is granted so the slave sees IDLE
  always_comb
  begin
    o_payload = '0;
    if (!i_grant.none)
      o_payload = i_payload[sel_idx];
  end

  // Index must hit an existing port
  always_comb
  begin
    if (!i_grant.none)
      a_idx_range: assert final (sel_idx < `MTX_NUM_PORTS);
  end

endmodule

// File: hdl/out_stage_arb.sv
// Output stage fixed-priority arbiter

`include "ahb_mtx_macros.svh"

module out_stage_arb
(
  input  logic                      HCLK,
  input  logic                      HRESETn,
  input  logic [`MTX_NUM_PORTS-1:0] i_req,        // Qualified port requests
  input  logic                      i_hreadymux,  // Transfer done on the slave
  input  ahb_pkg::ahb_addr_t        i_addr_sel,   // Phase of the granted port
  output mtx_pkg::grant_t           o_grant
);

  import ahb_pkg::*;
  import mtx_pkg::*;

  grant_t grant_q;       // Address phase owner
  grant_t grant_d;
  logic   lock_held_q;   // Locked sequence running through this port
  logic   lock_held_d;
  logic   lock_arb;      // Mastlock masked by sel or lock_held_q
  logic   burst_hold;    // Granted port mid burst
  logic   hold_grant;

  // ----------------------------------------------------------------------
  // Hold conditions
  // ----------------------------------------------------------------------
  // A master may address another slave inside a locked sequence, so the
  // mastlock alone keeps the grant once the sequence has started here
  assign lock_arb   = i_addr_sel.mastlock & (i_addr_sel.sel | lock_held_q);
  assign burst_hold = i_addr_sel.sel &
                      ((i_addr_sel.trans == SEQ) | (i_addr_sel.trans == BUSY));
  assign hold_grant = lock_arb | burst_hold;  // Both zero while none set

  // Lock tracking
  always_comb
  begin
    lock_held_d = lock_held_q;
    if (i_addr_sel.sel & i_addr_sel.mastlock &
        ((i_addr_sel.trans == NONSEQ) | (i_addr_sel.trans == SEQ)))
      lock_held_d = 1'b1;              // Locked beat accepted here
    else if (!i_addr_sel.mastlock)
      lock_held_d = 1'b0;              // Sequence over
  end

  // ----------------------------------------------------------------------
  // Priority select
  // ----------------------------------------------------------------------
  always_comb
  begin
    grant_d = grant_q;
    if (!hold_grant)
    begin
      grant_d.port = '0;
      grant_d.none = 1'b1;
      // Walk down so the lowest requester is written last
      for (int i = `MTX_NUM_PORTS - 1; i >= 0; i--)
      begin
        if (i_req[i])
        begin
          grant_d.port = port_idx_t'(i);
          grant_d.none = 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // State registers
  // ----------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      grant_q.port <= '0;
      grant_q.none <= 1'b1;        // Nobody owns the slave
      lock_held_q  <= 1'b0;
    end
    else if (i_hreadymux)          // Only between address phases
    begin
      grant_q     <= grant_d;
      lock_held_q <= lock_held_d;
    end
  end

  assign o_grant = grant_q;

  // Granted index names a real port
  a_grant_range: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !grant_q.none |-> (grant_q.port < `MTX_NUM_PORTS));

  // Stalled address phase keeps its owner
  a_grant_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hreadymux |=> $stable(grant_q));

endmodule

// File: hdl/mtx_pkg.sv
// Matrix arbitration types

`include "ahb_mtx_macros.svh"

package mtx_pkg;

  // Input port number, 0 is highest priority
  typedef logic [`MTX_PORT_W-1:0] port_idx_t;

  // ----------------------------------------------------------------------
  // Arbiter result
  // ----------------------------------------------------------------------
  // port is only meaningful while none is clear
  typedef struct packed
  {
    port_idx_t port;  // Granted input port
    logic      none;  // No port owns the slave
  } grant_t;

endpackage

// File: hdl/ahb_pkg.sv
// AHB protocol types

`include "ahb_mtx_macros.svh"

package ahb_pkg;

  // ----------------------------------------------------------------------
  // Transfer kind
  // ----------------------------------------------------------------------
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Burst paused by master
    NONSEQ = 2'b10,  // First beat or single
    SEQ    = 2'b11   // Following beat of a burst
  } htrans_e;

  // ----------------------------------------------------------------------
  // Address/control phase of one port
  // ----------------------------------------------------------------------
  // Field order sets the packed layout with sel as the MSB
  typedef struct packed
  {
    logic                   sel;       // HSEL for this slave
    logic [`AHB_ADDR_W-1:0] addr;      // HADDR
    htrans_e                trans;     // HTRANS
    logic                   write;     // HWRITE
    logic [2:0]             size;      // HSIZE
    logic [2:0]             burst;     // HBURST
    logic [3:0]             prot;      // HPROT
    logic [2:0]             master;    // HMASTER, up to 8 masters
    logic                   mastlock;  // HMASTLOCK
  } ahb_addr_t;

  // ----------------------------------------------------------------------
  // Data phase payload
  // ----------------------------------------------------------------------
  typedef logic [`AHB_DATA_W-1:0] ahb_wdata_t;  // HWDATA

endpackage

// File: hdl/ahb_mtx_macros.svh
// Bus matrix widths and port count

`ifndef AHB_MTX_MACROS_SVH
`define AHB_MTX_MACROS_SVH

// ----------------------------------------------------------------------
// AHB bus widths
// ----------------------------------------------------------------------
`define AHB_ADDR_W     32  // HADDR width
`define AHB_DATA_W     32  // HWDATA width

// ----------------------------------------------------------------------
// Output stage connectivity
// ----------------------------------------------------------------------
// Three input stages reach this slave port through the sparse matrix
`define MTX_NUM_PORTS  3   // Input ports competing for the slave
`define MTX_PORT_W     2   // Bits needed for a port index

`endif
